// ==== hdl/fifo_pkg.sv ====
package fifo_pkg;

	// Storage geometry shared by the controllers and the memory
	localparam int ADDR_W = 4;
	localparam int DEPTH = 1 << ADDR_W;
	localparam int DATA_W = 8;

	// Index into the storage array
	typedef logic [ADDR_W-1:0] addr_t;

	// The bit above the address bits flips on every wrap.
	// Equal pointers with equal wrap bits mean empty, and different wrap bits mean full
	typedef logic [ADDR_W:0] ptr_t;

	// One stored entry
	typedef logic [DATA_W-1:0] data_t;

	// Occupancy and threshold values run from 0 to DEPTH inclusive
	typedef logic [ADDR_W:0] level_t;

endpackage

// ==== hdl/fifo_mem_if.sv ====
`timescale 1ns/1ps

interface fifo_mem_if
	import fifo_pkg::*;
();

	// Write port
	logic  we;
	addr_t waddr;
	data_t wdata;

	// Read port
	logic  re;
	addr_t raddr;

	// Push controller side
	modport writer (
		output we,
		output waddr,
		output wdata
	);

	// Pop controller side
	modport reader (
		output re,
		output raddr
	);

	// The storage sees both ports
	modport store (
		input we,
		input waddr,
		input wdata,
		input re,
		input raddr
	);

endinterface

// ==== hdl/fifo_push_ctl.sv ====
`timescale 1ns/1ps

module fifo_push_ctl
	import fifo_pkg::*;
(
	input  logic       rclk,
	input  logic       rst_n,
	input  logic       wen,
	input  data_t      wr_data,
	input  level_t     upaf,
	input  ptr_t       rptr_next,
	output ptr_t       wptr_next,
	output logic       full,
	output logic       full_minus_one,
	output logic       almost_full,
	output logic       overflow,
	fifo_mem_if.writer mem
);

	ptr_t   wptr;
	logic   wr_accept;
	level_t level_next;
	level_t free_next;
	logic   full_d;
	logic   full_minus_one_d;
	logic   almost_full_d;

	// A write while full is dropped and never reaches the storage
	assign wr_accept = wen & ~full;

	assign wptr_next = wptr + ptr_t'(wr_accept);

	// The entry lands at the current pointer, which advances at the same edge
	assign mem.we    = wr_accept;
	assign mem.waddr = wptr[ADDR_W-1:0];
	assign mem.wdata = wr_data;

	// Both next pointers belong to the same edge
	// The difference is the occupancy the flags must show after that edge
	always_comb begin
		level_next = level_t'(wptr_next - rptr_next);
		free_next = level_t'(DEPTH) - level_next;
	end

	always_comb begin
		full_d = (level_next == level_t'(DEPTH));
		full_minus_one_d = (level_next == level_t'(DEPTH - 1));
		almost_full_d = (free_next < upaf);
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
		end else begin
			wptr <= wptr_next;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
			full_minus_one <= 1'b0;
			almost_full <= 1'b0;
		end else begin
			full <= full_d;
			full_minus_one <= full_minus_one_d;
			almost_full <= almost_full_d;
		end
	end

	// Only a write attempt updates overflow
	// A dropped write sets it and an accepted one clears it
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			overflow <= 1'b0;
		end else if (wen) begin
			overflow <= full;
		end
	end

endmodule

// ==== hdl/fifo_pop_ctl.sv ====
`timescale 1ns/1ps

module fifo_pop_ctl
	import fifo_pkg::*;
(
	input  logic       rclk,
	input  logic       rst_n,
	input  logic       ren,
	input  level_t     upae,
	input  ptr_t       wptr_next,
	output ptr_t       rptr_next,
	output logic       rd_valid,
	output logic       empty,
	output logic       empty_plus_one,
	output logic       almost_empty,
	output logic       underflow,
	fifo_mem_if.reader mem
);

	ptr_t   rptr;
	logic   rd_accept;
	level_t level_next;
	logic   empty_d;
	logic   empty_plus_one_d;
	logic   almost_empty_d;

	// The read strobe is masked while empty
	// The storage never sees a read of an entry that has not been written
	assign rd_accept = ren & ~empty;

	assign rptr_next = rptr + ptr_t'(rd_accept);

	assign mem.re    = rd_accept;
	assign mem.raddr = rptr[ADDR_W-1:0];

	// Occupancy after this edge, with this edge's write and read both counted
	always_comb begin
		level_next = level_t'(wptr_next - rptr_next);
	end

	always_comb begin
		empty_d = (level_next == '0);
		empty_plus_one_d = (level_next == level_t'(1));
		almost_empty_d = (level_next < upae);
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			rptr <= '0;
		end else begin
			rptr <= rptr_next;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			empty <= 1'b1;
			empty_plus_one <= 1'b0;
			almost_empty <= 1'b1;
		end else begin
			empty <= empty_d;
			empty_plus_one <= empty_plus_one_d;
			almost_empty <= almost_empty_d;
		end
	end

	// The storage returns data one edge after the read, so valid follows the same way
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_accept;
		end
	end

	// Only a read attempt updates underflow
	// A read while empty sets it and an accepted read clears it
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			underflow <= 1'b0;
		end else if (ren) begin
			underflow <= empty;
		end
	end

endmodule

// ==== hdl/fifo_ram.sv ====
`timescale 1ns/1ps

module fifo_ram
	import fifo_pkg::*;
(
	input  logic      rclk,
	fifo_mem_if.store mem,
	output data_t     rd_data
);

	data_t entries [DEPTH];

	// Write port stores at the edge where we is high
	always_ff @(posedge rclk) begin
		if (mem.we) begin
			entries[mem.waddr] <= mem.wdata;
		end
	end

	// The output register loads only on a read
	// Between reads it holds the last entry returned
	always_ff @(posedge rclk) begin
		if (mem.re) begin
			rd_data <= entries[mem.raddr];
		end
	end

endmodule

// ==== hdl/fifo_top.sv ====
`timescale 1ns/1ps

module fifo_top
	import fifo_pkg::*;
(
	input  logic   rclk,
	input  logic   rst_n,
	input  logic   wen,
	input  logic   ren,
	input  data_t  wr_data,
	input  level_t upaf,
	input  level_t upae,
	output data_t  rd_data,
	output logic   rd_valid,
	output logic   full,
	output logic   full_minus_one,
	output logic   almost_full,
	output logic   overflow,
	output logic   empty,
	output logic   empty_plus_one,
	output logic   almost_empty,
	output logic   underflow
);

	// Each side compares its own next pointer with the other's
	ptr_t wptr_next;
	ptr_t rptr_next;

	fifo_mem_if mem_if ();

	fifo_push_ctl push_ctl_inst (
		.rclk           (rclk),
		.rst_n          (rst_n),
		.wen            (wen),
		.wr_data        (wr_data),
		.upaf           (upaf),
		.rptr_next      (rptr_next),
		.wptr_next      (wptr_next),
		.full           (full),
		.full_minus_one (full_minus_one),
		.almost_full    (almost_full),
		.overflow       (overflow),
		.mem            (mem_if.writer)
	);

	fifo_pop_ctl pop_ctl_inst (
		.rclk           (rclk),
		.rst_n          (rst_n),
		.ren            (ren),
		.upae           (upae),
		.wptr_next      (wptr_next),
		.rptr_next      (rptr_next),
		.rd_valid       (rd_valid),
		.empty          (empty),
		.empty_plus_one (empty_plus_one),
		.almost_empty   (almost_empty),
		.underflow      (underflow),
		.mem            (mem_if.reader)
	);

	fifo_ram ram_inst (
		.rclk    (rclk),
		.mem     (mem_if.store),
		.rd_data (rd_data)
	);

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic rclk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 2;

	initial begin
		rclk = 1'b0;
		forever #(HALF_PERIOD) rclk = ~rclk;
	end

	// Release happens on a falling edge so it never races a rising one
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge rclk);
		@(negedge rclk);
		rst_n = 1'b1;
	end

endmodule

// ==== bench/fifo_asserts.sv ====
`timescale 1ns/1ps

module fifo_asserts (
	input logic rclk,
	input logic rst_n,
	input logic wen,
	input logic ren,
	input logic full,
	input logic empty,
	input logic overflow,
	input logic underflow,
	input logic rd_valid
);

	int fail_count = 0;

	assert property (@(posedge rclk) disable iff (!rst_n) !(full && empty))
		else begin
			fail_count = fail_count + 1;
			$error("full and empty are high at the same time");
		end

	// A new overflow needs a write attempt against a full FIFO one edge earlier
	assert property (@(posedge rclk) disable iff (!rst_n) $rose(overflow) |-> $past(wen && full))
		else begin
			fail_count = fail_count + 1;
			$error("overflow rose without a write while full");
		end

	assert property (@(posedge rclk) disable iff (!rst_n)
		$rose(underflow) |-> $past(ren && empty))
		else begin
			fail_count = fail_count + 1;
			$error("underflow rose without a read while empty");
		end

	assert property (@(posedge rclk) disable iff (!rst_n) (ren && !empty) |=> rd_valid)
		else begin
			fail_count = fail_count + 1;
			$error("rd_valid missing after an accepted read");
		end

	assert property (@(posedge rclk) disable iff (!rst_n) rd_valid |-> $past(ren && !empty))
		else begin
			fail_count = fail_count + 1;
			$error("rd_valid high without an accepted read");
		end

endmodule

// The top-level nets are the controller ports, so both flag sets are visible here
bind fifo_top fifo_asserts asserts_inst (
	.rclk      (rclk),
	.rst_n     (rst_n),
	.wen       (wen),
	.ren       (ren),
	.full      (full),
	.empty     (empty),
	.overflow  (overflow),
	.underflow (underflow),
	.rd_valid  (rd_valid)
);

// ==== bench/tb_fifo.sv ====
`timescale 1ns/1ps

module tb_fifo
	import fifo_pkg::*;
();

	localparam int RESET_CYCLES = 2;
	localparam int DATA_CYCLES = 300;
	localparam int BURST_LEN = 20;
	localparam int FILL_CYCLES = DEPTH + 3;
	localparam int EMPTY_CYCLES = DEPTH + 2;
	localparam int MID_LEVEL = 8;
	localparam int SIMUL_CYCLES = 40;
	localparam int THRESH_ROUNDS = 6;
	localparam int ROUND_CYCLES = 50;
	localparam int DRAIN_CYCLES = 2 * DEPTH;
	localparam int MARGIN = 50;
	localparam int CYCLE_LIMIT = RESET_CYCLES + DATA_CYCLES + FILL_CYCLES + EMPTY_CYCLES
		+ MID_LEVEL + SIMUL_CYCLES + THRESH_ROUNDS * (ROUND_CYCLES + 1) + DRAIN_CYCLES + MARGIN;

	logic   rclk;
	logic   rst_n;
	logic   wen;
	logic   ren;
	data_t  wr_data;
	level_t upaf;
	level_t upae;
	data_t  rd_data;
	logic   rd_valid;
	logic   full;
	logic   full_minus_one;
	logic   almost_full;
	logic   overflow;
	logic   empty;
	logic   empty_plus_one;
	logic   almost_empty;
	logic   underflow;

	// Reference model state
	data_t model_q[$];
	logic  exp_ovf;
	logic  exp_udf;
	logic  exp_valid;
	data_t exp_data;

	int    seed = 32'h9884;
	int    cycle_count = 0;
	string test_name = "reset";

	tb_clock clock_inst (
		.rclk  (rclk),
		.rst_n (rst_n)
	);

	fifo_top fifo_top_inst (
		.rclk           (rclk),
		.rst_n          (rst_n),
		.wen            (wen),
		.ren            (ren),
		.wr_data        (wr_data),
		.upaf           (upaf),
		.upae           (upae),
		.rd_data        (rd_data),
		.rd_valid       (rd_valid),
		.full           (full),
		.full_minus_one (full_minus_one),
		.almost_full    (almost_full),
		.overflow       (overflow),
		.empty          (empty),
		.empty_plus_one (empty_plus_one),
		.almost_empty   (almost_empty),
		.underflow      (underflow)
	);

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAILED %s: %s expected %0h, actual %0h", test_name, name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_outputs();
		int level;
		level = model_q.size();
		check_value("full", int'(level == DEPTH), int'(full));
		check_value("full_minus_one", int'(level == DEPTH - 1), int'(full_minus_one));
		check_value("almost_full", int'((DEPTH - level) < int'(upaf)), int'(almost_full));
		check_value("empty", int'(level == 0), int'(empty));
		check_value("empty_plus_one", int'(level == 1), int'(empty_plus_one));
		check_value("almost_empty", int'(level < int'(upae)), int'(almost_empty));
		check_value("overflow", int'(exp_ovf), int'(overflow));
		check_value("underflow", int'(exp_udf), int'(underflow));
		check_value("rd_valid", int'(exp_valid), int'(rd_valid));
		if (exp_valid) begin
			check_value("rd_data", int'(exp_data), int'(rd_data));
		end
	endtask

	// Drive at the falling edge, step the model at the rising edge, check at the next fall
	task automatic run_cycle(input logic w, input logic r, input data_t d);
		logic rd_ok;
		logic wr_ok;
		wen = w;
		ren = r;
		wr_data = d;
		@(posedge rclk);
		rd_ok = r && (model_q.size() != 0);
		wr_ok = w && (model_q.size() != DEPTH);
		if (w) begin
			exp_ovf = (model_q.size() == DEPTH);
		end
		if (r) begin
			exp_udf = (model_q.size() == 0);
		end
		exp_valid = rd_ok;
		if (rd_ok) begin
			exp_data = model_q.pop_front();
		end
		if (wr_ok) begin
			model_q.push_back(d);
		end
		@(negedge rclk);
		check_outputs();
	endtask

	// Bursty traffic alternates write-heavy and read-heavy stretches
	task automatic run_traffic(input int cycles, input logic bursty);
		logic w;
		logic r;
		logic write_phase;
		for (int i = 0; i < cycles; i++) begin
			write_phase = ((i / BURST_LEN) % 2 == 0);
			if (bursty) begin
				w = write_phase ? (($random(seed) & 3) != 0) : (($random(seed) & 3) == 0);
				r = write_phase ? (($random(seed) & 3) == 0) : (($random(seed) & 3) != 0);
			end else begin
				w = (($random(seed) & 1) != 0);
				r = (($random(seed) & 1) != 0);
			end
			run_cycle(w, r, data_t'($random(seed)));
		end
	endtask

	task automatic drain_fifo();
		while (model_q.size() != 0) begin
			run_cycle(1'b0, 1'b1, '0);
		end
	endtask

	always @(posedge rclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		wen = 1'b0;
		ren = 1'b0;
		wr_data = '0;
		upaf = level_t'(3);
		upae = level_t'(5);
		exp_ovf = 1'b0;
		exp_udf = 1'b0;
		exp_valid = 1'b0;
		exp_data = '0;

		@(posedge rst_n);
		check_value("empty", 1, int'(empty));
		check_value("almost_empty", 1, int'(almost_empty));
		check_value("empty_plus_one", 0, int'(empty_plus_one));
		check_value("full", 0, int'(full));
		check_value("full_minus_one", 0, int'(full_minus_one));
		check_value("almost_full", 0, int'(almost_full));
		check_value("overflow", 0, int'(overflow));
		check_value("underflow", 0, int'(underflow));
		check_value("rd_valid", 0, int'(rd_valid));

		test_name = "data_order";
		run_traffic(DATA_CYCLES, 1'b1);
		drain_fifo();

		test_name = "fill_to_full";
		for (int i = 0; i < DEPTH; i++) begin
			run_cycle(1'b1, 1'b0, data_t'($random(seed)));
		end
		run_cycle(1'b1, 1'b0, 8'hee);
		run_cycle(1'b0, 1'b1, '0);
		run_cycle(1'b1, 1'b0, data_t'($random(seed)));

		test_name = "drain_to_empty";
		for (int i = 0; i < DEPTH; i++) begin
			run_cycle(1'b0, 1'b1, '0);
		end
		run_cycle(1'b0, 1'b1, '0);
		run_cycle(1'b0, 1'b0, '0);

		test_name = "simultaneous";
		for (int i = 0; i < MID_LEVEL; i++) begin
			run_cycle(1'b1, 1'b0, data_t'($random(seed)));
		end
		for (int i = 0; i < SIMUL_CYCLES; i++) begin
			run_cycle(1'b1, 1'b1, data_t'($random(seed)));
		end
		drain_fifo();

		test_name = "random_thresholds";
		for (int r = 0; r < THRESH_ROUNDS; r++) begin
			upaf = level_t'($unsigned($random(seed)) % (DEPTH + 1));
			upae = level_t'($unsigned($random(seed)) % (DEPTH + 1));
			run_cycle(1'b0, 1'b0, '0);
			run_traffic(ROUND_CYCLES, 1'b0);
		end

		if (fifo_top_inst.asserts_inst.fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", fifo_top_inst.asserts_inst.fail_count);
			$display("RESULT: FAIL");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

// ==== tb.f ====
hdl/fifo_pkg.sv
hdl/fifo_mem_if.sv
hdl/fifo_push_ctl.sv
hdl/fifo_pop_ctl.sv
hdl/fifo_ram.sv
hdl/fifo_top.sv
bench/tb_clock.sv
bench/fifo_asserts.sv
bench/tb_fifo.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fifo -f tb.f -o Vtb_fifo

output=$(./obj_dir/Vtb_fifo 2>&1) || true
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
	exit 0
else
	exit 1
fi
